// File: src/wide_tcdm_config.svh
`ifndef WIDE_TCDM_CONFIG_SVH
`define WIDE_TCDM_CONFIG_SVH

// number of word-interleaved memory banks
`define WT_NB_BANKS 8

// 32-bit words carried by one wide access
`define WT_NB_WORDS 4

// width of one bank word and of the byte address
`define WT_WORD_WIDTH 32
`define WT_ADDR_WIDTH 32

// log2 of the rows in each bank, 64 rows
`define WT_BANK_ROWS_LOG2 6

// request FIFO entries, 0 removes the FIFO
`define WT_FIFO_DEPTH 2

`endif

// File: src/wide_tcdm_pkg.sv
`default_nettype none

`include "wide_tcdm_config.svh"

package wide_tcdm_pkg;

  // one bank word and its byte enables
  typedef logic [`WT_WORD_WIDTH-1:0] word_t;
  typedef logic [`WT_WORD_WIDTH/8-1:0] word_be_t;

  // wide accelerator data and byte enables, all words side by side
  typedef logic [`WT_NB_WORDS*`WT_WORD_WIDTH-1:0] wide_data_t;
  typedef logic [`WT_NB_WORDS*`WT_WORD_WIDTH/8-1:0] wide_be_t;

  // accelerator byte address
  typedef logic [`WT_ADDR_WIDTH-1:0] byte_addr_t;

  // bank index, also used as rotation amount
  typedef logic [$clog2(`WT_NB_BANKS)-1:0] bank_sel_t;

  // row inside one bank
  typedef logic [`WT_BANK_ROWS_LOG2-1:0] bank_row_t;

  // occupancy of the request FIFO
  typedef enum logic [1:0] {
    EMPTY,
    PARTIAL,
    FULL
  } fifo_state_t;

endpackage

`default_nettype wire

// File: src/wide_core_if.sv
`timescale 1ns/1ps
`default_nettype none

// wide accelerator-side port, four words per request
interface wide_core_if;

  // request fields, held stable while req is high and gnt is low
  logic                      req;
  logic                      wen;
  wide_tcdm_pkg::byte_addr_t add;
  wide_tcdm_pkg::wide_be_t   be;
  wide_tcdm_pkg::wide_data_t data;

  // grant and in-order read response
  logic                      gnt;
  logic                      r_valid;
  wide_tcdm_pkg::wide_data_t r_data;

  modport requester (
    output req,
    output wen,
    output add,
    output be,
    output data,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  modport responder (
    input  req,
    input  wen,
    input  add,
    input  be,
    input  data,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

`default_nettype wire

// File: src/bank_if.sv
`timescale 1ns/1ps
`default_nettype none

// one 32-bit bank link, addressed by row
interface bank_if;

  logic                     req;
  // high means write
  logic                     wen;
  wide_tcdm_pkg::bank_row_t row;
  wide_tcdm_pkg::word_be_t  be;
  wide_tcdm_pkg::word_t     data;
  logic                     gnt;
  logic                     r_valid;
  wide_tcdm_pkg::word_t     r_data;

  modport initiator (
    output req,
    output wen,
    output row,
    output be,
    output data,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  modport target (
    input  req,
    input  wen,
    input  row,
    input  be,
    input  data,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

`default_nettype wire

// File: src/wide_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module wide_req_fifo #(
  parameter int unsigned DEPTH = `WT_FIFO_DEPTH
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  wide_core_if.responder up,
  wide_core_if.requester down
);

  localparam int unsigned ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // request storage, one slot per entry
  logic                      wen_q  [DEPTH];
  wide_tcdm_pkg::byte_addr_t add_q  [DEPTH];
  wide_tcdm_pkg::wide_be_t   be_q   [DEPTH];
  wide_tcdm_pkg::wide_data_t data_q [DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w-1:0] wr_ptr_inc;
  logic [ptr_w-1:0] rd_ptr_inc;

  wide_tcdm_pkg::fifo_state_t state_q;
  wide_tcdm_pkg::fifo_state_t state_d;

  logic push;
  logic pop;

  // accept upstream while any slot is free
  assign up.gnt   = (state_q != wide_tcdm_pkg::FULL);
  assign down.req = (state_q != wide_tcdm_pkg::EMPTY);

  assign push = up.req & up.gnt;
  assign pop  = down.req & down.gnt;

  // circular pointers, wrap at the last slot
  assign wr_ptr_inc = (wr_ptr_q == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_inc = (rd_ptr_q == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

  // occupancy FSM
  // no pop when empty and no push when full, the handshake masks them
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      wide_tcdm_pkg::EMPTY: begin
        if (push) begin
          state_d = (DEPTH == 1) ? wide_tcdm_pkg::FULL : wide_tcdm_pkg::PARTIAL;
        end
      end
      wide_tcdm_pkg::PARTIAL: begin
        if (push && !pop && (wr_ptr_inc == rd_ptr_q)) begin
          state_d = wide_tcdm_pkg::FULL;
        end else if (pop && !push && (rd_ptr_inc == wr_ptr_q)) begin
          state_d = wide_tcdm_pkg::EMPTY;
        end
      end
      wide_tcdm_pkg::FULL: begin
        if (pop) begin
          state_d = (DEPTH == 1) ? wide_tcdm_pkg::EMPTY : wide_tcdm_pkg::PARTIAL;
        end
      end
      default: state_d = wide_tcdm_pkg::EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= wide_tcdm_pkg::EMPTY;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      // synchronous flush, stored requests are dropped
      state_q  <= wide_tcdm_pkg::EMPTY;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (push) begin
        wr_ptr_q <= wr_ptr_inc;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_inc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wen_q[wr_ptr_q]  <= up.wen;
      add_q[wr_ptr_q]  <= up.add;
      be_q[wr_ptr_q]   <= up.be;
      data_q[wr_ptr_q] <= up.data;
    end
  end

  // head entry drives downstream, visible one cycle after its push
  assign down.wen  = wen_q[rd_ptr_q];
  assign down.add  = add_q[rd_ptr_q];
  assign down.be   = be_q[rd_ptr_q];
  assign down.data = data_q[rd_ptr_q];

  // banks answer in order, responses need no queue
  assign up.r_valid = down.r_valid;
  assign up.r_data  = down.r_data;

endmodule

`default_nettype wire

// File: src/bank_rotator.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module bank_rotator (
  input  wide_tcdm_pkg::bank_sel_t order_i,
  input  wide_tcdm_pkg::bank_sel_t resp_order_i,
  bank_if.target                   virt [`WT_NB_WORDS],
  bank_if.initiator                phys [`WT_NB_BANKS]
);

  localparam int unsigned nb_words = `WT_NB_WORDS;
  localparam int unsigned nb_banks = `WT_NB_BANKS;

  // virtual ports padded to the bank count, entries past the last word stay idle
  logic                     v_req  [nb_banks];
  logic                     v_wen  [nb_banks];
  wide_tcdm_pkg::bank_row_t v_row  [nb_banks];
  wide_tcdm_pkg::word_be_t  v_be   [nb_banks];
  wide_tcdm_pkg::word_t     v_data [nb_banks];

  // physical response side gathered for indexed selection
  logic                     p_gnt    [nb_banks];
  logic                     p_rvalid [nb_banks];
  wide_tcdm_pkg::word_t     p_rdata  [nb_banks];

  for (genvar w = 0; w < nb_words; w++) begin : g_virt
    wide_tcdm_pkg::bank_sel_t req_bank;
    wide_tcdm_pkg::bank_sel_t rsp_bank;

    assign v_req[w]  = virt[w].req;
    assign v_wen[w]  = virt[w].wen;
    assign v_row[w]  = virt[w].row;
    assign v_be[w]   = virt[w].be;
    assign v_data[w] = virt[w].data;

    // word w sits on bank w+order, modulo the bank count
    assign req_bank = wide_tcdm_pkg::bank_sel_t'(w) + order_i;
    // read data returns with the rotation that was live at acceptance
    assign rsp_bank = wide_tcdm_pkg::bank_sel_t'(w) + resp_order_i;

    assign virt[w].gnt     = p_gnt[req_bank];
    assign virt[w].r_valid = p_rvalid[rsp_bank];
    assign virt[w].r_data  = p_rdata[rsp_bank];
  end

  for (genvar n = nb_words; n < nb_banks; n++) begin : g_nil
    assign v_req[n]  = 1'b0;
    assign v_wen[n]  = 1'b0;
    assign v_row[n]  = '0;
    assign v_be[n]   = '0;
    assign v_data[n] = '0;
  end

  for (genvar k = 0; k < nb_banks; k++) begin : g_phys
    wide_tcdm_pkg::bank_sel_t src;

    // bank k takes virtual word k-order
    assign src = wide_tcdm_pkg::bank_sel_t'(k) - order_i;

    assign phys[k].req  = v_req[src];
    assign phys[k].wen  = v_wen[src];
    assign phys[k].row  = v_row[src];
    assign phys[k].be   = v_be[src];
    assign phys[k].data = v_data[src];

    assign p_gnt[k]    = phys[k].gnt;
    assign p_rvalid[k] = phys[k].r_valid;
    assign p_rdata[k]  = phys[k].r_data;
  end

endmodule

`default_nettype wire

// File: src/wide_port_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module wide_port_interconnect #(
  parameter int unsigned FIFO_DEPTH = `WT_FIFO_DEPTH
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  wide_core_if.responder core,
  bank_if.initiator      banks [`WT_NB_BANKS]
);

  localparam int unsigned nb_words = `WT_NB_WORDS;
  localparam int unsigned nb_banks = `WT_NB_BANKS;
  localparam int unsigned word_w   = $bits(wide_tcdm_pkg::word_t);
  localparam int unsigned be_w     = $bits(wide_tcdm_pkg::word_be_t);
  localparam int unsigned sel_w    = $bits(wide_tcdm_pkg::bank_sel_t);
  localparam int unsigned row_w    = $bits(wide_tcdm_pkg::bank_row_t);
  // bits 1:0 are the byte offset, then bank select, then row
  localparam int unsigned sel_lsb  = 2;
  localparam int unsigned row_lsb  = sel_lsb + sel_w;

  wide_core_if post ();
  bank_if      virt [nb_words] ();
  bank_if      phys [nb_banks] ();

  wide_tcdm_pkg::bank_sel_t offset;
  wide_tcdm_pkg::bank_sel_t resp_order_q;
  wide_tcdm_pkg::bank_row_t base_row;

  logic [nb_words-1:0] virt_gnt;
  logic [nb_words-1:0] virt_rvalid;
  logic                all_gnt;
  logic [nb_banks-1:0] rvalid_q;

  if (FIFO_DEPTH == 0) begin : g_no_fifo
    assign post.req     = core.req;
    assign post.wen     = core.wen;
    assign post.add     = core.add;
    assign post.be      = core.be;
    assign post.data    = core.data;
    assign core.gnt     = post.gnt;
    assign core.r_valid = post.r_valid;
    assign core.r_data  = post.r_data;
  end else begin : g_fifo
    wide_req_fifo #(
      .DEPTH ( FIFO_DEPTH )
    ) i_fifo (
      .clk_i   ( clk_i   ),
      .rst_ni  ( rst_ni  ),
      .clear_i ( clear_i ),
      .up      ( core    ),
      .down    ( post    )
    );
  end

  assign offset   = post.add[sel_lsb +: sel_w];
  assign base_row = post.add[row_lsb +: row_w];

  // all four target banks free, otherwise no bank sees the request
  assign all_gnt = &virt_gnt;

  for (genvar w = 0; w < nb_words; w++) begin : g_word
    assign virt[w].req  = post.req & all_gnt;
    assign virt[w].wen  = post.wen;
    assign virt[w].be   = post.be[be_w*w +: be_w];
    assign virt[w].data = post.data[word_w*w +: word_w];
    // words that wrap past the last bank use the next row
    assign virt[w].row  = ((int'(offset) + w) >= nb_banks) ? base_row + 1'b1 : base_row;

    assign virt_gnt[w]    = virt[w].gnt;
    assign virt_rvalid[w] = virt[w].r_valid;
    assign post.r_data[word_w*w +: word_w] = virt[w].r_data;
  end

  assign post.gnt     = all_gnt;
  assign post.r_valid = &virt_rvalid;

  // rotation of the read in flight, steers the response one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_order_q <= '0;
    end else if (post.req && post.gnt && !post.wen) begin
      resp_order_q <= offset;
    end
  end

  for (genvar k = 0; k < nb_banks; k++) begin : g_bank
    assign banks[k].req  = phys[k].req;
    assign banks[k].wen  = phys[k].wen;
    assign banks[k].row  = phys[k].row;
    assign banks[k].be   = phys[k].be;
    assign banks[k].data = phys[k].data;
    assign phys[k].gnt    = banks[k].gnt;
    assign phys[k].r_data = banks[k].r_data;
    // only reads issued through this port count as its responses
    assign phys[k].r_valid = rvalid_q[k] & banks[k].r_valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q[k] <= 1'b0;
      end else begin
        rvalid_q[k] <= banks[k].req & banks[k].gnt & ~banks[k].wen;
      end
    end
  end

  bank_rotator i_rotator (
    .order_i      ( offset       ),
    .resp_order_i ( resp_order_q ),
    .virt         ( virt         ),
    .phys         ( phys         )
  );

endmodule

`default_nettype wire

// File: src/tcdm_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module tcdm_bank (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    busy_i,
  bank_if.target  port
);

  localparam int unsigned nb_rows = 1 << `WT_BANK_ROWS_LOG2;
  localparam int unsigned nb_lanes = $bits(wide_tcdm_pkg::word_be_t);

  wide_tcdm_pkg::word_t mem [nb_rows];
  wide_tcdm_pkg::word_t r_data_q;
  logic                 r_valid_q;
  logic                 accept;

  // another initiator holds the bank while busy
  assign port.gnt = ~busy_i;
  assign accept   = port.req & port.gnt;

  always_ff @(posedge clk_i) begin
    if (accept && port.wen) begin
      // byte lanes written only where enabled
      for (int b = 0; b < nb_lanes; b++) begin
        if (port.be[b]) begin
          mem[port.row][8*b +: 8] <= port.data[8*b +: 8];
        end
      end
    end
    if (accept && !port.wen) begin
      r_data_q <= mem[port.row];
    end
  end

  // read data valid exactly one cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= accept & ~port.wen;
    end
  end

  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;

endmodule

`default_nettype wire

// File: src/wide_tcdm_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module wide_tcdm_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  logic                      wen_i,
  input  wide_tcdm_pkg::byte_addr_t add_i,
  input  wide_tcdm_pkg::wide_be_t   be_i,
  input  wide_tcdm_pkg::wide_data_t data_i,
  input  logic [`WT_NB_BANKS-1:0]   bank_busy_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output wide_tcdm_pkg::wide_data_t r_data_o
);

  // accelerator side link
  wide_core_if core ();
  // one link per memory bank
  bank_if      bank_link [`WT_NB_BANKS] ();

  assign core.req  = req_i;
  assign core.wen  = wen_i;
  assign core.add  = add_i;
  assign core.be   = be_i;
  assign core.data = data_i;

  assign gnt_o     = core.gnt;
  assign r_valid_o = core.r_valid;
  assign r_data_o  = core.r_data;

  wide_port_interconnect #(
    .FIFO_DEPTH ( `WT_FIFO_DEPTH )
  ) i_interconnect (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .clear_i ( clear_i   ),
    .core    ( core      ),
    .banks   ( bank_link )
  );

  for (genvar k = 0; k < `WT_NB_BANKS; k++) begin : g_bank
    // busy input models contention from other initiators
    tcdm_bank i_bank (
      .clk_i  ( clk_i          ),
      .rst_ni ( rst_ni         ),
      .busy_i ( bank_busy_i[k] ),
      .port   ( bank_link[k]   )
    );
  end

endmodule

`default_nettype wire

// File: testbench/wide_tcdm_props.sv
`timescale 1ns/1ps
`default_nettype none

// handshake properties on the subsystem top-level ports
module wide_tcdm_props (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      wen_i,
  input  wide_tcdm_pkg::byte_addr_t add_i,
  input  wide_tcdm_pkg::wide_be_t   be_i,
  input  wide_tcdm_pkg::wide_data_t data_i,
  input  logic                      gnt_o,
  input  logic                      r_valid_o
);

  // set once the first read has transferred
  logic read_seen;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_seen <= 1'b0;
    end else if (req_i && gnt_o && !wen_i) begin
      read_seen <= 1'b1;
    end
  end

  // no response before a read was ever accepted, reset included
  no_early_rvalid: assert property (@(posedge clk_i) !read_seen |-> !r_valid_o)
    else $error("r_valid_o high before any read was accepted");

  // a stalled request keeps req and all of its fields
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_o) |=> (req_i && $stable(wen_i) && $stable(add_i)
                           && $stable(be_i) && $stable(data_i)))
    else $error("request changed while waiting for gnt_o");

  handshake_known: assert property (@(posedge clk_i) !$isunknown({gnt_o, r_valid_o}))
    else $error("gnt_o or r_valid_o is unknown");

endmodule

`default_nettype wire

// File: testbench/wide_tcdm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wide_tcdm_config.svh"

module wide_tcdm_tb;

  // word address is row * banks + bank over all banks
  localparam int unsigned mem_words = `WT_NB_BANKS << `WT_BANK_ROWS_LOG2;
  // the tests with preload take about 300 cycles
  localparam int unsigned timeout_cycles = 4000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      clear_i;
  logic                      req_i;
  logic                      wen_i;
  wide_tcdm_pkg::byte_addr_t add_i;
  wide_tcdm_pkg::wide_be_t   be_i;
  wide_tcdm_pkg::wide_data_t data_i;
  logic [`WT_NB_BANKS-1:0]   bank_busy_i;
  logic                      gnt_o;
  logic                      r_valid_o;
  wide_tcdm_pkg::wide_data_t r_data_o;

  // reference memory and the read data still owed by the DUT in order
  wide_tcdm_pkg::word_t      ref_mem [mem_words];
  wide_tcdm_pkg::wide_data_t exp_q [$];

  int unsigned checks;
  int unsigned errors;
  int unsigned cycles;

  wide_tcdm_subsystem dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_i       ( req_i       ),
    .wen_i       ( wen_i       ),
    .add_i       ( add_i       ),
    .be_i        ( be_i        ),
    .data_i      ( data_i      ),
    .bank_busy_i ( bank_busy_i ),
    .gnt_o       ( gnt_o       ),
    .r_valid_o   ( r_valid_o   ),
    .r_data_o    ( r_data_o    )
  );

  bind wide_tcdm_subsystem wide_tcdm_props i_props (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( req_i     ),
    .wen_i     ( wen_i     ),
    .add_i     ( add_i     ),
    .be_i      ( be_i      ),
    .data_i    ( data_i    ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_wide(input string name, input wide_tcdm_pkg::wide_data_t got,
                            input wide_tcdm_pkg::wide_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // word w of a wide access sits at word address add/4 + w modulo the memory size
  function automatic int unsigned word_index(input wide_tcdm_pkg::byte_addr_t add,
                                             input int unsigned w);
    return ((add >> 2) + w) % mem_words;
  endfunction

  function automatic wide_tcdm_pkg::wide_data_t model_read(input wide_tcdm_pkg::byte_addr_t add);
    wide_tcdm_pkg::wide_data_t r;
    for (int w = 0; w < `WT_NB_WORDS; w++) begin
      r[`WT_WORD_WIDTH*w +: `WT_WORD_WIDTH] = ref_mem[word_index(add, w)];
    end
    return r;
  endfunction

  task automatic model_write(input wide_tcdm_pkg::byte_addr_t add,
                             input wide_tcdm_pkg::wide_be_t be,
                             input wide_tcdm_pkg::wide_data_t data);
    int unsigned idx;
    for (int w = 0; w < `WT_NB_WORDS; w++) begin
      idx = word_index(add, w);
      for (int b = 0; b < `WT_WORD_WIDTH/8; b++) begin
        if (be[4*w+b]) begin
          ref_mem[idx][8*b +: 8] = data[`WT_WORD_WIDTH*w + 8*b +: 8];
        end
      end
    end
  endtask

  // fill value built from the full word address
  function automatic wide_tcdm_pkg::word_t fill_word(input int unsigned idx);
    return {7'h5a, 9'(idx), 7'h3c, 9'(idx)};
  endfunction

  // hold the request until accepted and update the model in accept order
  task automatic issue(input logic wen, input wide_tcdm_pkg::byte_addr_t add,
                       input wide_tcdm_pkg::wide_be_t be, input wide_tcdm_pkg::wide_data_t data);
    bit done;
    done   = 1'b0;
    req_i  = 1'b1;
    wen_i  = wen;
    add_i  = add;
    be_i   = be;
    data_i = data;
    while (!done) begin
      @(negedge clk_i);
      if (gnt_o === 1'b1) begin
        done = 1'b1;
        if (wen) begin
          model_write(add, be, data);
        end else begin
          exp_q.push_back(model_read(add));
        end
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic release_bus();
    req_i = 1'b0;
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // every read response is compared against the oldest owed value
  always @(negedge clk_i) begin
    if (rst_ni && r_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected read response with no read outstanding");
      end else begin
        check_wide("r_data_o", r_data_o, exp_q.pop_front());
      end
    end
  end

  task automatic preload_memory();
    for (int a = 0; a < mem_words; a += `WT_NB_WORDS) begin
      issue(1'b1, wide_tcdm_pkg::byte_addr_t'(a) << 2, '1,
            {fill_word(a+3), fill_word(a+2), fill_word(a+1), fill_word(a)});
    end
    release_bus();
  endtask

  task automatic reset_and_aligned();
    int unsigned err0;
    err0 = errors;
    @(negedge clk_i);
    check_bit("r_valid_o", r_valid_o, 1'b0);
    check_bit("gnt_o", gnt_o, 1'b1);
    @(posedge clk_i);
    #2;
    // bank 0 row 8
    issue(1'b1, 32'h0000_0100, '1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
    issue(1'b0, 32'h0000_0100, '1, '0);
    release_bus();
    wait_responses();
    report_test("reset and aligned access", err0);
  endtask

  task automatic wrap_into_next_row();
    int unsigned err0;
    err0 = errors;
    // bank 6 row 3 so words 2 and 3 land on banks 0 and 1 of row 4
    issue(1'b1, 32'h0000_0078, '1, 128'hcafe_0003_cafe_0002_cafe_0001_cafe_0000);
    issue(1'b0, 32'h0000_0080, '1, '0);
    issue(1'b0, 32'h0000_0078, '1, '0);
    release_bus();
    wait_responses();
    report_test("bank wrap into next row", err0);
  endtask

  task automatic byte_enable_write();
    int unsigned err0;
    err0 = errors;
    issue(1'b1, 32'h0000_0244, '1, 128'h1111_2222_3333_4444_5555_6666_7777_8888);
    issue(1'b1, 32'h0000_0244, 16'hc3a5, 128'haaaa_bbbb_cccc_dddd_eeee_ffff_0000_9999);
    issue(1'b0, 32'h0000_0244, '1, '0);
    release_bus();
    wait_responses();
    report_test("byte enable write", err0);
  endtask

  task automatic busy_bank_stall();
    int unsigned err0;
    err0 = errors;
    bank_busy_i = 8'b0000_0100;
    // banks 4 to 7 do not touch the busy bank
    issue(1'b1, 32'h0000_0150, '1, 128'hdead_beef_0bad_f00d_1234_5678_9abc_def0);
    issue(1'b0, 32'h0000_0150, '1, '0);
    release_bus();
    wait_responses();
    // both reads cover bank 2 and queue up in the FIFO
    issue(1'b0, 32'h0000_00a0, '1, '0);
    issue(1'b0, 32'h0000_00c4, '1, '0);
    fork
      // a third read waits on the full FIFO
      issue(1'b0, 32'h0000_0104, '1, '0);
      begin
        @(negedge clk_i);
        check_bit("gnt_o", gnt_o, 1'b0);
        repeat (10) begin
          @(negedge clk_i);
          check_bit("r_valid_o", r_valid_o, 1'b0);
        end
        @(posedge clk_i);
        #2;
        bank_busy_i = '0;
      end
    join
    release_bus();
    wait_responses();
    report_test("busy bank back-pressure", err0);
  endtask

  task automatic random_accesses();
    int unsigned err0;
    logic        wen;
    wide_tcdm_pkg::byte_addr_t add;
    err0 = errors;
    for (int i = 0; i < 50; i++) begin
      wen = 1'($urandom_range(0, 1));
      add = wide_tcdm_pkg::byte_addr_t'($urandom_range(0, mem_words - 1)) << 2;
      issue(wen, add, wide_tcdm_pkg::wide_be_t'($urandom),
            {$urandom, $urandom, $urandom, $urandom});
    end
    release_bus();
    wait_responses();
    report_test("random accesses", err0);
  endtask

  task automatic back_to_back_reads();
    int unsigned err0;
    err0 = errors;
    // a new start bank on each read
    for (int i = 0; i < 6; i++) begin
      issue(1'b0, wide_tcdm_pkg::byte_addr_t'(i*5 + 3) << 2, '1, '0);
    end
    release_bus();
    wait_responses();
    report_test("back-to-back reads", err0);
  endtask

  initial begin
    void'($urandom(32'h56f4eb58));
    checks      = 0;
    errors      = 0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    req_i       = 1'b0;
    wen_i       = 1'b0;
    add_i       = '0;
    be_i        = '0;
    data_i      = '0;
    bank_busy_i = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    reset_and_aligned();
    preload_memory();
    wrap_into_next_row();
    byte_enable_write();
    busy_bank_stall();
    random_accesses();
    back_to_back_reads();
    $display("tests finished, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run limit counted in clock cycles
  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, a request or response never arrived", cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: wide_tcdm.f
+incdir+src
src/wide_tcdm_pkg.sv
src/wide_core_if.sv
src/bank_if.sv
src/wide_req_fifo.sv
src/bank_rotator.sv
src/wide_port_interconnect.sv
src/tcdm_bank.sv
src/wide_tcdm_subsystem.sv
testbench/wide_tcdm_props.sv
testbench/wide_tcdm_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the wide TCDM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module wide_tcdm_tb \
  -f wide_tcdm.f \
  -o wide_tcdm_sim

./obj_dir/wide_tcdm_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
